// File: starfield_pkg.sv
package starfield_pkg;

    // Each star layer runs a 23-bit maximal-length style shift register.
    localparam int LFSR_W = 23;

    // APB byte offsets of the scroll registers.
    localparam logic [11:0] REG_HPOS0 = 12'h000;  // horizontal scroll of layer 0.
    localparam logic [11:0] REG_VPOS0 = 12'h004;  // vertical scroll of layer 0.
    localparam logic [11:0] REG_HPOS1 = 12'h008;  // horizontal scroll of layer 1.
    localparam logic [11:0] REG_VPOS1 = 12'h00c;  // vertical scroll of layer 1.

    // Default raster geometry for a typical arcade monitor.
    localparam int H_TOTAL  = 512;  // pixels per line including blanking.
    localparam int H_ACTIVE = 384;  // visible pixels per line.
    localparam int V_TOTAL  = 262;  // lines per frame including blanking.
    localparam int V_ACTIVE = 224;  // visible lines per frame.
    localparam int CEN_DIV  = 4;    // system clocks per pixel.

    // Scroll registers as written by the host.
    typedef struct packed {
        logic [8:0] hpos0;  // pre-step count of layer 0.
        logic [8:0] vpos0;  // line offset of layer 0.
        logic [8:0] hpos1;  // pre-step count of layer 1.
        logic [8:0] vpos1;  // line offset of layer 1.
    } scroll_regs_t;

    // Raster state shared by the star layers and the outside consumer.
    typedef struct packed {
        logic       hb;       // horizontal blanking.
        logic       vb;       // vertical blanking.
        logic       pxl_cen;  // one-clock pixel enable.
        logic [8:0] vdump;    // current line number.
    } raster_t;

    // Star codes of both layers.
    // Bits 8:7 are zero, 6:4 hold the colour and 3:0 the intensity.
    // An intensity of 4'hf marks a transparent pixel.
    typedef struct packed {
        logic [8:0] star0;  // code of layer 0.
        logic [8:0] star1;  // code of layer 1.
    } star_pix_t;

endpackage

// File: star_regs.sv
module star_regs
    import starfield_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [11:0]  paddr,    // byte address within the register block.
    input  logic         psel,     // the slave is selected.
    input  logic         penable,  // high in the access phase.
    input  logic         pwrite,   // high for a write transfer.
    input  logic [31:0]  pwdata,   // only the low nine bits are stored.
    output logic [31:0]  prdata,   // read data, valid during access.
    output logic         pready,   // transfers never wait.
    output logic         pslverr,  // raised for unmapped or unaligned addresses.
    output scroll_regs_t regs      // scroll values for both layers.
);

    scroll_regs_t regs_q;  // storage for the four scroll registers.
    logic         access;  // the transfer is in its access phase.
    logic         hit;     // the address matches one of the four offsets.
    logic [3:0]   wr_sel;  // one-hot register select for writes.
    logic [8:0]   rd_val;  // value of the addressed register.

    assign access = psel & penable;  // setup cycles have no side effects.

    // Address decode.
    // Only the four exact offsets hit, so any unaligned address misses too.
    always_comb begin
        hit    = 1'b1;
        wr_sel = 4'b0000;
        rd_val = 9'd0;
        case (paddr)
            REG_HPOS0: begin
                wr_sel = 4'b0001;       // first layer horizontal scroll.
                rd_val = regs_q.hpos0;
            end
            REG_VPOS0: begin
                wr_sel = 4'b0010;       // first layer vertical scroll.
                rd_val = regs_q.vpos0;
            end
            REG_HPOS1: begin
                wr_sel = 4'b0100;       // second layer horizontal scroll.
                rd_val = regs_q.hpos1;
            end
            REG_VPOS1: begin
                wr_sel = 4'b1000;       // second layer vertical scroll.
                rd_val = regs_q.vpos1;
            end
            default: begin
                hit = 1'b0;             // the slave answers with an error.
            end
        endcase
    end

    // Writes take effect on the edge that closes the access phase.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs_q <= '0;  // all scroll offsets start at zero.
        end else if (access && pwrite) begin
            if (wr_sel[0]) begin
                regs_q.hpos0 <= pwdata[8:0];
            end
            if (wr_sel[1]) begin
                regs_q.vpos0 <= pwdata[8:0];
            end
            if (wr_sel[2]) begin
                regs_q.hpos1 <= pwdata[8:0];
            end
            if (wr_sel[3]) begin
                regs_q.vpos1 <= pwdata[8:0];
            end
        end
    end

    // Read data is zero-extended and stays zero outside a good read.
    assign prdata  = (access && !pwrite && hit) ? {23'd0, rd_val} : 32'd0;
    assign pslverr = access & ~hit;  // the error is only flagged during access.
    assign pready  = 1'b1;           // zero wait states on every transfer.
    assign regs    = regs_q;

endmodule

// File: raster_timing.sv
module raster_timing
    import starfield_pkg::*;
#(
    parameter int H_TOTAL  = starfield_pkg::H_TOTAL,   // pixels per line.
    parameter int H_ACTIVE = starfield_pkg::H_ACTIVE,  // visible pixels per line.
    parameter int V_TOTAL  = starfield_pkg::V_TOTAL,   // lines per frame.
    parameter int V_ACTIVE = starfield_pkg::V_ACTIVE,  // visible lines per frame.
    parameter int CEN_DIV  = starfield_pkg::CEN_DIV    // clocks per pixel.
) (
    input  logic    clk,
    input  logic    rst_n,
    output raster_t raster
);

    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;  // divider width.
    localparam int HW = $clog2(H_TOTAL + 1);                   // pixel counter width.

    localparam logic [CW-1:0] CEN_LAST = CW'(CEN_DIV - 1);  // last divider state.
    localparam logic [HW-1:0] H_LAST   = HW'(H_TOTAL - 1);  // last pixel of a line.
    localparam logic [HW-1:0] H_ACT    = HW'(H_ACTIVE);     // first blanked pixel.
    localparam logic [8:0]    V_LAST   = 9'(V_TOTAL - 1);   // last line of a frame.
    localparam logic [8:0]    V_ACT    = 9'(V_ACTIVE);      // first blanked line.

    logic [CW-1:0] cen_cnt;  // clock divider for the pixel enable.
    logic [HW-1:0] hcnt;     // pixel position within the line.
    logic [8:0]    vcnt;     // line position within the frame.
    logic          pxl_cen;  // one pulse every CEN_DIV clocks.

    assign pxl_cen = (cen_cnt == CEN_LAST);  // a divider of one keeps it high.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            hcnt    <= '0;  // the raster starts at line 0, pixel 0.
            vcnt    <= '0;
        end else begin
            cen_cnt <= pxl_cen ? '0 : cen_cnt + CW'(1);
            if (pxl_cen) begin
                if (hcnt == H_LAST) begin
                    hcnt <= '0;                                  // wrap to a new line.
                    vcnt <= (vcnt == V_LAST) ? 9'd0 : vcnt + 9'd1;
                end else begin
                    hcnt <= hcnt + HW'(1);
                end
            end
        end
    end

    // The blanking flags come straight from the counters.
    always_comb begin
        raster.hb      = (hcnt >= H_ACT);  // right of the visible area.
        raster.vb      = (vcnt >= V_ACT);  // below the visible area.
        raster.pxl_cen = pxl_cen;
        raster.vdump   = vcnt;             // the line number seeds the layers.
    end

endmodule

// File: star_lfsr.sv
module star_lfsr
    import starfield_pkg::*;
#(
    parameter int LAYER = 0  // selects the seed pattern of this layer.
) (
    input  logic              clk,
    input  logic              rst_n,
    input  raster_t           raster,  // blanking flags, pixel enable and line.
    input  logic [8:0]        hpos,    // number of steps taken during blanking.
    input  logic [8:0]        vpos,    // offset added to the line number.
    output logic [LFSR_W-1:0] poly     // current shift register state.
);

    localparam logic LB = (LAYER != 0);  // layer 1 inverts part of the seed.

    logic              load;       // any blanking holds the layer in load.
    logic              last_load;  // load as seen on the previous clock.
    logic              load_edge;  // first clock of a blanking period.
    logic [8:0]        cnt;        // remaining pre-steps.
    logic              cnt_hi;     // pre-steps are still pending.
    logic [8:0]        v;          // scrolled line number.
    logic [LFSR_W-1:0] seed;       // reload value for this line.
    logic              shift;      // advance the register on this clock.
    logic              feedback;   // bit inserted at the bottom.

    assign load      = raster.hb | raster.vb;
    assign load_edge = load & ~last_load;
    assign cnt_hi    = |cnt;
    assign v         = vpos + raster.vdump;  // the sum wraps at nine bits.

    // The top nibble mixes the layer pattern with the scrolled line.
    // The middle holds two rotated slices of the same sum.
    // The bottom ten bits keep the register away from the all-zero state.
    assign seed = {
        {LB, ~LB, ~LB, LB} ^ {v[3:2], v[7:6]},
        v[3:0],
        v[8:4],
        10'h155 ^ {10{LB}}
    };

    // Blanking clocks only shift while pre-steps remain.
    // Active video shifts once per pixel.
    assign shift    = load ? cnt_hi : raster.pxl_cen;
    assign feedback = ~(poly[21] ^ poly[17]);  // XNOR taps at 22 and 18.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            poly      <= '0;
            cnt       <= '0;
            last_load <= 1'b0;
        end else begin
            last_load <= load;
            if (load_edge) begin
                poly <= seed;  // the reseed wins over any pending step.
                cnt  <= hpos;  // horizontal scroll becomes the step count.
            end else if (shift) begin
                poly <= {poly[LFSR_W-2:0], feedback};
                if (cnt_hi) begin
                    cnt <= cnt - 9'd1;  // leftover steps also drain in active video.
                end
            end
        end
    end

endmodule

// File: star_shade.sv
module star_shade
    import starfield_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [LFSR_W-1:0] poly0,  // register state of layer 0.
    input  logic [LFSR_W-1:0] poly1,  // register state of layer 1.
    output star_pix_t         pix     // registered star codes.
);

    localparam logic [8:0] NO_STAR = 9'h00f;  // colour zero and transparent.

    star_pix_t pix_next;  // codes for the current register states.

    // A star shows only when the nine middle bits are all set.
    // The colour field is passed through even for empty pixels.
    function automatic logic [8:0] shade(input logic [LFSR_W-1:0] p);
        logic       bright;
        logic [3:0] level;
        bright = &p[15:7];
        level  = bright ? p[3:0] : 4'hf;
        return {2'b00, p[6:4], level};
    endfunction

    always_comb begin
        pix_next.star0 = shade(poly0);
        pix_next.star1 = shade(poly1);
    end

    // One register stage so the codes line up one clock after each pixel enable.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix.star0 <= NO_STAR;
            pix.star1 <= NO_STAR;
        end else begin
            pix <= pix_next;
        end
    end

endmodule

// File: starfield_top.sv
module starfield_top
    import starfield_pkg::*;
#(
    parameter int H_TOTAL  = starfield_pkg::H_TOTAL,   // pixels per line.
    parameter int H_ACTIVE = starfield_pkg::H_ACTIVE,  // visible pixels per line.
    parameter int V_TOTAL  = starfield_pkg::V_TOTAL,   // lines per frame.
    parameter int V_ACTIVE = starfield_pkg::V_ACTIVE,  // visible lines per frame.
    parameter int CEN_DIV  = starfield_pkg::CEN_DIV    // clocks per pixel.
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output star_pix_t   pix,        // star codes of both layers.
    output raster_t     raster_out  // raster state for aligning the pixels.
);

    scroll_regs_t      regs;    // scroll values from the host.
    raster_t           raster;  // timing shared by both layers.
    logic [LFSR_W-1:0] poly0;   // state of layer 0.
    logic [LFSR_W-1:0] poly1;   // state of layer 1.

    star_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .regs    (regs)
    );

    raster_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .CEN_DIV  (CEN_DIV)
    ) u_raster (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster)
    );

    // The two layers differ only in their seed pattern and scroll values.
    star_lfsr #(.LAYER(0)) u_lfsr0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster),
        .hpos   (regs.hpos0),
        .vpos   (regs.vpos0),
        .poly   (poly0)
    );

    star_lfsr #(.LAYER(1)) u_lfsr1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster),
        .hpos   (regs.hpos1),
        .vpos   (regs.vpos1),
        .poly   (poly1)
    );

    star_shade u_shade (
        .clk   (clk),
        .rst_n (rst_n),
        .poly0 (poly0),
        .poly1 (poly1),
        .pix   (pix)
    );

    assign raster_out = raster;  // the pixel codes lag this by one clock.

endmodule

// File: tb_starfield.sv
module tb_starfield
    import starfield_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SIM_H_TOTAL  = 40;    // short lines keep the frames quick.
    localparam int SIM_H_ACTIVE = 32;
    localparam int SIM_V_TOTAL  = 12;
    localparam int SIM_V_ACTIVE = 8;
    localparam int SIM_CEN_DIV  = 2;
    localparam int WAIT_LIMIT   = 2000;  // about two frames of clocks.

    logic        clk;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    star_pix_t   pix;
    raster_t     raster_out;

    integer            seed;             // state of the random sequence.
    integer            errors;           // failures seen by the stimulus process.
    integer            checks;
    integer            tests;
    integer            mon_errors;       // failures seen by the pixel monitor.
    integer            mon_checks;
    integer            stars;            // bright pixels predicted so far.
    integer            blank_checks;     // pixels compared during blanking.
    logic [11:0]       offs [4];         // the four register offsets in order.
    logic [8:0]        sh_hpos [2];      // host view of the scroll registers.
    logic [8:0]        sh_vpos [2];
    logic [LFSR_W-1:0] m_poly [2];       // model of each layer register.
    logic [8:0]        m_cnt [2];        // model of each pre-step counter.
    logic              m_last_load;
    logic              load;
    logic [8:0]        vsum;
    logic              mon_ready;        // set once the monitor has seen reset.
    star_pix_t         exp_pix;          // codes expected after the next edge.
    logic              exp_bright [2];
    int                m_cen;            // model of the pixel enable divider.
    int                m_h;              // model of the pixel position.
    int                m_v;              // model of the line position.
    raster_t           exp_raster;       // raster state expected at the ports.

    starfield_top #(
        .H_TOTAL  (SIM_H_TOTAL),
        .H_ACTIVE (SIM_H_ACTIVE),
        .V_TOTAL  (SIM_V_TOTAL),
        .V_ACTIVE (SIM_V_ACTIVE),
        .CEN_DIV  (SIM_CEN_DIV)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .pix        (pix),
        .raster_out (raster_out)
    );

    always begin
        clk = 1'b0;
        #10;
        clk = 1'b1;  // rising edges at 10 ns, 30 ns and so on.
        #10;
    end

    // the seed holds the mixed layer nibble, the low and high sum bits and a fixed ten-bit tail.
    function automatic logic [LFSR_W-1:0] make_seed(input logic layer, input logic [8:0] v);
        logic [3:0] pat;
        logic [9:0] tail;
        pat  = layer ? 4'b1001 : 4'b0110;
        tail = layer ? 10'h2aa : 10'h155;  // layer 1 takes the inverted tail.
        return {pat ^ {v[3:2], v[7:6]}, v[3:0], v[8:4], tail};
    endfunction

    function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] p);
        return {p[LFSR_W-2:0], ~(p[21] ^ p[17])};  // inverted tap sum enters at bit 0.
    endfunction

    function automatic logic is_bright(input logic [LFSR_W-1:0] p);
        return &p[15:7];
    endfunction

    function automatic logic [8:0] shade_code(input logic [LFSR_W-1:0] p);
        return {2'b00, p[6:4], is_bright(p) ? p[3:0] : 4'hf};
    endfunction

    function automatic int reg_index(input logic [11:0] addr);
        case (addr)
            REG_HPOS0: return 0;
            REG_VPOS0: return 1;
            REG_HPOS1: return 2;
            REG_VPOS1: return 3;
            default:   return -1;  // anything else must answer with an error.
        endcase
    endfunction

    function automatic logic [31:0] shadow_value(input int k);
        case (k)
            0:       return {23'd0, sh_hpos[0]};
            1:       return {23'd0, sh_vpos[0]};
            2:       return {23'd0, sh_hpos[1]};
            default: return {23'd0, sh_vpos[1]};
        endcase
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("sim failed");
        $finish;
    endtask

    task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_star(input string name, input logic [8:0] got, input logic [8:0] want,
                              input logic bright);
        mon_checks++;
        assert (got === want) else begin
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, want, got);
            mon_errors++;
        end
        assert (got[8:7] == 2'b00) else begin
            $display("ERR t=%0t %s[8:7] exp=0 got=%b", $time, name, got[8:7]);
            mon_errors++;
        end
        assert (bright || got[3:0] == 4'hf) else begin
            $display("ERR t=%0t %s[3:0] exp=f got=%h", $time, name, got[3:0]);
            mon_errors++;
        end
        if (bright) begin
            stars++;
        end
    endtask

    task automatic await_ready();
        int n;
        n = 0;
        while (pready !== 1'b1) begin
            if (n >= WAIT_LIMIT) begin
                abort_on_timeout("pready never rose during an APB access");
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic await_vb(input logic level);
        int n;
        n = 0;
        while (raster_out.vb !== level) begin
            if (n >= WAIT_LIMIT) begin
                abort_on_timeout("vertical blanking did not reach the expected level");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic await_line(input logic [8:0] line);
        int n;
        n = 0;
        while (!(raster_out.vdump == line && !raster_out.vb && !raster_out.hb)) begin
            if (n >= WAIT_LIMIT) begin
                abort_on_timeout("the raster never reached the requested active line");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_frames(input int n);
        for (int f = 0; f < n; f++) begin
            await_vb(1'b1);
            await_vb(1'b0);  // the frame starts where vertical blanking ends.
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;  // setup phase.
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;  // access phase.
        await_ready();
        @(negedge clk);
        err = pslverr;
        @(posedge clk);  // the register takes the data on this edge.
        case (reg_index(addr))
            0: sh_hpos[0] = data[8:0];
            1: sh_vpos[0] = data[8:0];
            2: sh_hpos[1] = data[8:0];
            3: sh_vpos[1] = data[8:0];
            default: ;
        endcase
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        await_ready();
        @(negedge clk);
        data = prdata;  // read data is only valid in the access phase.
        err  = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // pixel monitor, sampling at the falling edge where all DUT outputs are settled.
    always @(negedge clk) begin
        if (!rst_n) begin
            m_poly[0]      = '0;
            m_poly[1]      = '0;
            m_cnt[0]       = '0;
            m_cnt[1]       = '0;
            m_last_load    = 1'b0;
            m_cen          = 0;
            m_h            = 0;      // the raster restarts at line 0, pixel 0.
            m_v            = 0;
            exp_pix.star0  = 9'h00f;  // reset leaves both layers transparent.
            exp_pix.star1  = 9'h00f;
            exp_bright[0]  = 1'b0;
            exp_bright[1]  = 1'b0;
            mon_errors     = 0;
            mon_checks     = 0;
            stars          = 0;
            blank_checks   = 0;
            mon_ready      = 1'b1;
        end else if (mon_ready === 1'b1) begin
            exp_raster.hb      = (m_h >= SIM_H_ACTIVE);  // blanking follows the counts.
            exp_raster.vb      = (m_v >= SIM_V_ACTIVE);
            exp_raster.pxl_cen = (m_cen == SIM_CEN_DIV - 1);
            exp_raster.vdump   = m_v[8:0];
            mon_checks++;
            assert (raster_out === exp_raster) else begin
                $display("ERR t=%0t raster_out exp=%h got=%h", $time, exp_raster, raster_out);
                mon_errors++;
            end
            if (exp_raster.pxl_cen) begin
                m_cen = 0;
                if (m_h == SIM_H_TOTAL - 1) begin
                    m_h = 0;  // a new line starts after the last pixel.
                    m_v = (m_v == SIM_V_TOTAL - 1) ? 0 : m_v + 1;
                end else begin
                    m_h = m_h + 1;
                end
            end else begin
                m_cen = m_cen + 1;
            end
            check_star("pix.star0", pix.star0, exp_pix.star0, exp_bright[0]);
            check_star("pix.star1", pix.star1, exp_pix.star1, exp_bright[1]);
            load = raster_out.hb | raster_out.vb;
            if (load) begin
                blank_checks++;
            end
            exp_pix.star0 = shade_code(m_poly[0]);  // the shader registers the current state.
            exp_pix.star1 = shade_code(m_poly[1]);
            exp_bright[0] = is_bright(m_poly[0]);
            exp_bright[1] = is_bright(m_poly[1]);
            for (int l = 0; l < 2; l++) begin
                vsum = sh_vpos[l] + raster_out.vdump;  // nine-bit wrap like the hardware.
                if (load && !m_last_load) begin
                    m_poly[l] = make_seed(l[0], vsum);
                    m_cnt[l]  = sh_hpos[l];
                end else if (load ? (m_cnt[l] != 9'd0) : raster_out.pxl_cen) begin
                    m_poly[l] = lfsr_next(m_poly[l]);
                    if (m_cnt[l] != 9'd0) begin
                        m_cnt[l] = m_cnt[l] - 9'd1;  // pending steps drain on every shift.
                    end
                end
            end
            m_last_load = load;
        end
    end

    initial begin
        integer      r;
        integer      e0;
        integer      b0;
        int          k;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [11:0] addr;
        logic        err;
        seed    = 32'h082a7ef0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        sh_hpos[0] = '0;
        sh_hpos[1] = '0;
        sh_vpos[0] = '0;
        sh_vpos[1] = '0;
        offs[0] = REG_HPOS0;
        offs[1] = REG_VPOS0;
        offs[2] = REG_HPOS1;
        offs[3] = REG_VPOS1;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        e0 = errors + mon_errors;
        @(negedge clk);
        expect_val("pix.star0[3:0]", {28'd0, pix.star0[3:0]}, 32'hf);
        expect_val("pix.star1[3:0]", {28'd0, pix.star1[3:0]}, 32'hf);
        for (k = 0; k < 4; k++) begin
            apb_read(offs[k], rdata, err);
            expect_val("prdata", rdata, 32'd0);
            expect_val("pslverr", {31'd0, err}, 32'd0);
        end
        tests++;
        $display("test 1 reset values: %0d errors", errors + mon_errors - e0);

        e0 = errors + mon_errors;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            k = r & 3;
            data = $random(seed);
            apb_write(offs[k], data, err);
            expect_val("pslverr", {31'd0, err}, 32'd0);
            apb_read(offs[k], rdata, err);
            expect_val("prdata", rdata, {23'd0, data[8:0]});
        end
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            addr = r[11:0];
            if (reg_index(addr) >= 0) begin
                addr = addr + 12'd1;  // a mapped offset plus one is unaligned.
            end
            data = $random(seed);
            apb_write(addr, data, err);
            expect_val("pslverr", {31'd0, err}, 32'd1);
            apb_read(addr, rdata, err);
            expect_val("pslverr", {31'd0, err}, 32'd1);
            expect_val("prdata", rdata, 32'd0);
            for (k = 0; k < 4; k++) begin
                apb_read(offs[k], rdata, err);
                expect_val("prdata", rdata, shadow_value(k));
            end
        end
        tests++;
        $display("test 2 register access: %0d errors", errors + mon_errors - e0);

        e0 = errors + mon_errors;
        for (k = 0; k < 4; k++) begin
            data = $random(seed);
            apb_write(offs[k], data, err);
        end
        run_frames(3);  // one partial frame, then two whole ones.
        tests++;
        $display("test 3 random scroll frames: %0d stars, %0d errors", stars,
                 errors + mon_errors - e0);

        e0 = errors + mon_errors;
        b0 = blank_checks;
        data = $random(seed) & 32'hf;  // few enough steps to finish inside a line blank.
        apb_write(REG_HPOS0, data, err);
        data = $random(seed) & 32'hf;
        apb_write(REG_HPOS1, data, err);
        run_frames(2);
        tests++;
        $display("test 4 blanking pre-step: %0d blank pixels, %0d errors", blank_checks - b0,
                 errors + mon_errors - e0);

        e0 = errors + mon_errors;
        await_line(9'd3);
        r = $random(seed);
        data = {23'd0, sh_vpos[0] ^ (r[8:0] | 9'd1)};  // always a different offset.
        apb_write(REG_VPOS0, data, err);
        run_frames(2);
        tests++;
        $display("test 5 mid-frame vpos0 change: %0d errors", errors + mon_errors - e0);

        e0 = errors + mon_errors;
        for (k = 0; k < 4; k++) begin
            data = $random(seed);
            apb_write(offs[k], data, err);
        end
        run_frames(1);
        tests++;
        $display("test 6 star code format: %0d errors", errors + mon_errors - e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks + mon_checks,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: project.f
starfield_pkg.sv
star_regs.sv
raster_timing.sv
star_lfsr.sv
star_shade.sv
starfield_top.sv
tb_starfield.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module tb_starfield -o tb_starfield

./obj_dir/tb_starfield > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation completed"
